/* src/hdc_pkg.sv */
package hdc_pkg;

    // instruction word and address field
    localparam int inst_w = 16;
    localparam int addr_w = 10;

    // instruction bit positions

    // needs an item address, load or write-back
    localparam int op_addr = 15;

    // reg_2 source taken from the rotator
    localparam int op_perm = 14;

    // with op_addr: load item into reg_2
    // without: reg_2 <= reg_1 ^ source
    localparam int op_xor = 13;

    // with op_addr: write-back to item memory
    // without: store the source
    localparam int op_store = 12;

    // copy source into reg_1
    localparam int op_wr_r1 = 11;

    // end of program
    localparam int op_last = 10;

    // reg_2 <= bundler sign vector, no address form only
    localparam int op_sign = 9;

    // bundler counter width
    localparam int cnt_w = 8;

endpackage

/* src/hv_permute.sv */
module hv_permute #(
    parameter int DIM = 63
) (
    input  logic [DIM:0]               perm_in,
    input  logic [hdc_pkg::addr_w-1:0] perm_shift,
    output logic [DIM:0]               perm_out
);

    localparam int SW = $clog2(DIM + 1);

    logic [SW-1:0] shift_mod;
    logic [DIM:0]  stage [SW+1];

    // rotate amount modulo the vector length
    // reduces to a bit select when DIM+1 is a power of two
    assign shift_mod = SW'(perm_shift % (DIM + 1));

    assign stage[0] = perm_in;

    // one stage per shift bit, stage k rotates left by 2**k
    for (genvar k = 0; k < SW; k++) begin : g_stage
        localparam int R = 2 ** k;

        always_comb begin
            if (shift_mod[k]) begin
                stage[k+1] = {stage[k][DIM-R:0], stage[k][DIM:DIM-R+1]};
            end else begin
                stage[k+1] = stage[k];
            end
        end
    end

    assign perm_out = stage[SW];

endmodule

/* src/hv_rng.sv */
module hv_rng #(
    parameter int          DIM  = 63,
    parameter logic [31:0] SEED = 32'h2545f491
) (
    input  logic         clk,
    input  logic         arst_n,
    input  logic         gen,
    output logic [DIM:0] rand_num
);

    // one 32-bit xorshift lane per word of the vector
    localparam int LANES = (DIM + 1) / 32;

    logic [31:0] lane_q [LANES];

    // xorshift32 with shifts 13, 17, 5
    function automatic logic [31:0] xs32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    for (genvar l = 0; l < LANES; l++) begin : g_lane
        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                lane_q[l] <= SEED + 32'(l);
            end else if (gen) begin
                lane_q[l] <= xs32(lane_q[l]);
            end
        end

        assign rand_num[32*l +: 32] = lane_q[l];

        // a lane in the zero state stays at zero
        a_rng_nonzero: assert property (
            @(posedge clk) disable iff (!arst_n)
            lane_q[l] != '0
        );
    end

endmodule

/* src/hv_bundler.sv */
module hv_bundler #(
    parameter int DIM = 63
) (
    input  logic         clk,
    input  logic         arst_n,
    input  logic         run,
    input  logic         store,
    input  logic [DIM:0] core_result,
    output logic [DIM:0] sign_bit
);

    // symmetric bounds so that the most negative code is never reached
    localparam logic signed [hdc_pkg::cnt_w-1:0] CNT_MAX = (2 ** (hdc_pkg::cnt_w - 1)) - 1;
    localparam logic signed [hdc_pkg::cnt_w-1:0] CNT_MIN = -CNT_MAX;

    logic signed [hdc_pkg::cnt_w-1:0] cnt_q [DIM+1];

    for (genvar i = 0; i <= DIM; i++) begin : g_dim

        // up for a one, down for a zero, held at the bounds
        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                cnt_q[i] <= '0;
            end else if (!run) begin
                cnt_q[i] <= '0;
            end else if (store) begin
                if (core_result[i]) begin
                    if (cnt_q[i] != CNT_MAX) begin
                        cnt_q[i] <= cnt_q[i] + 1'b1;
                    end
                end else begin
                    if (cnt_q[i] != CNT_MIN) begin
                        cnt_q[i] <= cnt_q[i] - 1'b1;
                    end
                end
            end
        end

        // majority vote, a tie reads as zero
        assign sign_bit[i] = (cnt_q[i] > 0);

        a_cnt_bounds: assert property (
            @(posedge clk) disable iff (!arst_n)
            (cnt_q[i] >= CNT_MIN) && (cnt_q[i] <= CNT_MAX)
        );
    end

endmodule

/* src/hv_core.sv */
module hv_core #(
    parameter int DIM     = 63,
    parameter int THREADS = 4,
    parameter int ITEMS   = 512
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       run,
    input  logic                       gen,
    input  logic                       update_item,
    input  logic [hdc_pkg::addr_w-1:0] item_a,
    input  logic [DIM:0]               rand_num,
    input  logic                       get_v,
    input  logic [hdc_pkg::inst_w-1:0] get_d,
    input  logic [DIM:0]               sign_bit,
    input  logic [DIM:0]               perm_out,
    output logic [DIM:0]               perm_in,
    output logic [hdc_pkg::addr_w-1:0] perm_shift,
    output logic                       store,
    output logic                       last,
    output logic [DIM:0]               core_result
);

    localparam int IA_W = $clog2(ITEMS);
    localparam int TW   = $clog2(THREADS);

    // item memory and its registered read port
    logic [DIM:0]               item_mem [ITEMS];
    logic [DIM:0]               item_rd_q;

    // latched instruction and pending write-back
    logic [hdc_pkg::inst_w-1:0] inst_q;
    logic                       get_wb;
    logic                       wb_q;
    logic [IA_W-1:0]            wb_addr_q;
    logic                       exec_q;
    logic                       exec;

    // thread issue counter and thread of the executing instruction
    logic [TW-1:0]              thr_q;
    logic [TW-1:0]              exec_thr_q;

    // per-thread register files and their prefetched entries
    logic [DIM:0]               r1_file [THREADS];
    logic [DIM:0]               r2_file [THREADS];
    logic [DIM:0]               r1_q;
    logic [DIM:0]               r2_q;

    logic [DIM:0]               src;
    logic [DIM:0]               buff_q;

    assign get_wb = get_d[hdc_pkg::op_addr] & get_d[hdc_pkg::op_store];

    // control state, cleared while run is low
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exec_q <= 1'b0;
            wb_q   <= 1'b0;
            thr_q  <= '0;
        end else if (!run) begin
            exec_q <= 1'b0;
            wb_q   <= 1'b0;
            thr_q  <= '0;
        end else begin
            exec_q <= get_v;
            wb_q   <= get_v & get_wb;
            if (get_v) begin
                if (thr_q == TW'(THREADS - 1)) begin
                    thr_q <= '0;
                end else begin
                    thr_q <= thr_q + 1'b1;
                end
            end
        end
    end

    assign exec = exec_q & run;

    // write-back issues as a nop, only the flag and address carry it
    always_ff @(posedge clk) begin
        if (get_v) begin
            inst_q     <= get_wb ? '0 : get_d;
            wb_addr_q  <= get_d[IA_W-1:0];
            exec_thr_q <= thr_q;
        end
    end

    // single write port, write-back wins over random fill
    always_ff @(posedge clk) begin
        if (exec && wb_q) begin
            item_mem[wb_addr_q] <= src;
        end else if (gen && update_item) begin
            item_mem[item_a[IA_W-1:0]] <= rand_num;
        end
        item_rd_q <= item_mem[get_d[IA_W-1:0]];
    end

    // prefetch at the latch edge, ready for the exec cycle
    always_ff @(posedge clk) begin
        r1_q <= r1_file[thr_q];
        r2_q <= r2_file[thr_q];
    end

    assign perm_in    = r2_q;
    assign perm_shift = inst_q[hdc_pkg::addr_w-1:0];
    assign src        = inst_q[hdc_pkg::op_perm] ? perm_out : r2_q;

    // register file writes land at the end of exec
    always_ff @(posedge clk) begin
        if (exec) begin
            if (inst_q[hdc_pkg::op_addr]) begin
                // load item
                if (inst_q[hdc_pkg::op_xor]) begin
                    r2_file[exec_thr_q] <= item_rd_q;
                end
            end else begin
                if (inst_q[hdc_pkg::op_xor]) begin
                    r2_file[exec_thr_q] <= r1_q ^ src;
                end else if (inst_q[hdc_pkg::op_sign]) begin
                    r2_file[exec_thr_q] <= sign_bit;
                end
                if (inst_q[hdc_pkg::op_wr_r1]) begin
                    r1_file[exec_thr_q] <= src;
                end
            end
        end
    end

    // store and last pulses, store has priority
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            store <= 1'b0;
            last  <= 1'b0;
        end else if (!exec || inst_q[hdc_pkg::op_addr]) begin
            store <= 1'b0;
            last  <= 1'b0;
        end else begin
            store <= inst_q[hdc_pkg::op_store];
            last  <= inst_q[hdc_pkg::op_last] & ~inst_q[hdc_pkg::op_store];
        end
    end

    always_ff @(posedge clk) begin
        if (exec && !inst_q[hdc_pkg::op_addr] && inst_q[hdc_pkg::op_store]) begin
            buff_q <= src;
        end
    end

    // result bus idles at zero
    assign core_result = store ? buff_q : '0;

    a_store_last_excl: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(store && last)
    );

    // nothing executes while stopped, so no pulse follows
    a_exec_run: assert property (
        @(posedge clk) disable iff (!arst_n)
        !run |=> !store && !last
    );

endmodule

/* src/hdc_accel.sv */
module hdc_accel #(
    parameter int          DIM     = 63,
    parameter int          THREADS = 4,
    parameter int          ITEMS   = 512,
    parameter logic [31:0] SEED    = 32'h2545f491
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       run,
    input  logic                       gen,
    input  logic                       update_item,
    input  logic [hdc_pkg::addr_w-1:0] item_a,
    input  logic                       get_v,
    input  logic [hdc_pkg::inst_w-1:0] get_d,
    output logic                       store,
    output logic                       last,
    output logic [DIM:0]               core_result
);

    logic [DIM:0]               rand_num;
    logic [DIM:0]               perm_in;
    logic [hdc_pkg::addr_w-1:0] perm_shift;
    logic [DIM:0]               perm_out;
    logic [DIM:0]               sign_bit;

    hv_rng #(
        .DIM  (DIM),
        .SEED (SEED)
    ) i_hv_rng (
        .clk      (clk),
        .arst_n   (arst_n),
        .gen      (gen),
        .rand_num (rand_num)
    );

    hv_core #(
        .DIM     (DIM),
        .THREADS (THREADS),
        .ITEMS   (ITEMS)
    ) i_hv_core (
        .clk         (clk),
        .arst_n      (arst_n),
        .run         (run),
        .gen         (gen),
        .update_item (update_item),
        .item_a      (item_a),
        .rand_num    (rand_num),
        .get_v       (get_v),
        .get_d       (get_d),
        .sign_bit    (sign_bit),
        .perm_out    (perm_out),
        .perm_in     (perm_in),
        .perm_shift  (perm_shift),
        .store       (store),
        .last        (last),
        .core_result (core_result)
    );

    hv_permute #(
        .DIM (DIM)
    ) i_hv_permute (
        .perm_in    (perm_in),
        .perm_shift (perm_shift),
        .perm_out   (perm_out)
    );

    // majority of everything stored, fed back for op_sign
    hv_bundler #(
        .DIM (DIM)
    ) i_hv_bundler (
        .clk         (clk),
        .arst_n      (arst_n),
        .run         (run),
        .store       (store),
        .core_result (core_result),
        .sign_bit    (sign_bit)
    );

endmodule

/* dv/hdc_accel_checker.sv */
module hdc_accel_checker #(
    parameter int          DIM     = 63,
    parameter int          THREADS = 4,
    parameter int          ITEMS   = 512,
    parameter logic [31:0] SEED    = 32'h2545f491
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       run,
    input  logic                       gen,
    input  logic                       update_item,
    input  logic [hdc_pkg::addr_w-1:0] item_a,
    input  logic                       get_v,
    input  logic [hdc_pkg::inst_w-1:0] get_d,
    input  logic                       store,
    input  logic                       last,
    input  logic [DIM:0]               core_result,
    input  logic                       test_end,
    input  int                         test_num,
    input  int                         exp_stores,
    output int                         errors,
    output int                         tests_failed
);

    localparam int LANES = (DIM + 1) / 32;
    localparam int LIM   = 2 ** (hdc_pkg::cnt_w - 1) - 1;

    logic [31:0]  lane [LANES];
    logic [DIM:0] items [ITEMS];
    logic [DIM:0] r1 [THREADS];
    logic [DIM:0] r2 [THREADS];
    int           cnt [DIM+1];
    int           thr;
    int           seen_stores;
    int           test_errors;
    logic [DIM:0] rnd;
    logic [DIM:0] e1_res;
    logic [DIM:0] e2_res;
    logic         e1_store, e2_store, e1_last, e2_last;

    // standard xorshift32 step
    function automatic logic [31:0] next_lane(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [DIM:0] rotate_left(input logic [DIM:0] v, input int s);
        logic [DIM:0] r;
        for (int i = 0; i <= DIM; i++) begin
            r[(i + s) % (DIM + 1)] = v[i];
        end
        return r;
    endfunction

    task automatic clear_counts();
        for (int i = 0; i <= DIM; i++) begin
            cnt[i] = 0;
        end
    endtask

    // one instruction, applied at its strobe
    task automatic execute(input logic [hdc_pkg::inst_w-1:0] op);
        int           a;
        logic [DIM:0] src;
        a = int'(op[hdc_pkg::addr_w-1:0]) % ITEMS;
        if (op[hdc_pkg::op_addr]) begin
            if (op[hdc_pkg::op_store]) begin
                items[a] = r2[thr];
            end else if (op[hdc_pkg::op_xor]) begin
                r2[thr] = items[a];
            end
        end else begin
            src = op[hdc_pkg::op_perm] ? rotate_left(r2[thr], int'(op[hdc_pkg::addr_w-1:0]))
                                       : r2[thr];
            if (op[hdc_pkg::op_xor]) begin
                r2[thr] = r1[thr] ^ src;
            end else if (op[hdc_pkg::op_sign]) begin
                for (int i = 0; i <= DIM; i++) begin
                    r2[thr][i] = (cnt[i] > 0);
                end
            end
            if (op[hdc_pkg::op_wr_r1]) begin
                r1[thr] = src;
            end
            if (op[hdc_pkg::op_store]) begin
                e1_store = 1'b1;
                e1_res   = src;
                for (int i = 0; i <= DIM; i++) begin
                    if (src[i] && cnt[i] < LIM) begin
                        cnt[i]++;
                    end else if (!src[i] && cnt[i] > -LIM) begin
                        cnt[i]--;
                    end
                end
            end else if (op[hdc_pkg::op_last]) begin
                e1_last = 1'b1;
            end
        end
    endtask

    task automatic check_value(input string name, input logic [DIM:0] got,
                               input logic [DIM:0] exp);
        if (got !== exp) begin
            $display("ERROR time=%0t %s expected=%h got=%h", $time, name, exp, got);
            errors++;
            test_errors++;
        end
    endtask

    initial begin
        errors       = 0;
        tests_failed = 0;
        seen_stores  = 0;
        test_errors  = 0;
        thr          = 0;
        e1_store     = 1'b0;
        e2_store     = 1'b0;
        e1_last      = 1'b0;
        e2_last      = 1'b0;
        e1_res       = '0;
        e2_res       = '0;
    end

    // model steps on the same edge where the DUT samples its inputs
    always @(posedge clk) begin
        e2_store = e1_store;
        e2_last  = e1_last;
        e2_res   = e1_res;
        e1_store = 1'b0;
        e1_last  = 1'b0;
        e1_res   = '0;
        if (!arst_n) begin
            for (int l = 0; l < LANES; l++) begin
                lane[l] = SEED + 32'(l);
            end
            thr = 0;
            clear_counts();
            e2_store = 1'b0;
            e2_last  = 1'b0;
            e2_res   = '0;
        end else begin
            if (gen) begin
                for (int l = 0; l < LANES; l++) begin
                    rnd[32*l +: 32] = lane[l];
                    lane[l] = next_lane(lane[l]);
                end
                if (update_item) begin
                    items[int'(item_a) % ITEMS] = rnd;
                end
            end
            if (!run) begin
                thr = 0;
                clear_counts();
            end else if (get_v) begin
                execute(get_d);
                thr = (thr + 1) % THREADS;
            end
        end
    end

    // outputs are settled by the falling edge
    always @(negedge clk) begin
        check_value("store", {{DIM{1'b0}}, store}, {{DIM{1'b0}}, e2_store});
        check_value("last", {{DIM{1'b0}}, last}, {{DIM{1'b0}}, e2_last});
        check_value("core_result", core_result, e2_res);
        if (store === 1'b1) begin
            seen_stores++;
        end
        if (test_end) begin
            if (seen_stores != exp_stores) begin
                $display("test %0d saw %0d store pulses where %0d were expected",
                         test_num, seen_stores, exp_stores);
                errors++;
                test_errors++;
            end
            $display("test %0d: %s, %0d stores, %0d errors", test_num,
                     (test_errors == 0) ? "ok" : "FAILED", seen_stores, test_errors);
            if (test_errors != 0) begin
                tests_failed++;
            end
            seen_stores = 0;
            test_errors = 0;
        end
    end

endmodule

/* dv/hdc_accel_tb.sv */
module hdc_accel_tb;

    localparam int          DIM     = 63;
    localparam int          THREADS = 4;
    localparam int          ITEMS   = 512;
    localparam logic [31:0] SEED    = 32'h2545f491;
    localparam int          TESTS   = 6;
    localparam int          SHIFTS [4] = '{0, 5, 33, 70};

    logic                       clk, arst_n, run, gen, update_item, get_v;
    logic [hdc_pkg::addr_w-1:0] item_a;
    logic [hdc_pkg::inst_w-1:0] get_d;
    logic                       store, last, test_end;
    logic [DIM:0]               core_result;
    int                         test_num, exp_stores, errors, tests_failed;

    // stimulus table, one row per clock
    int                         row_fill  [$];
    logic [hdc_pkg::inst_w-1:0] row_inst  [$];
    bit                         row_run   [$];
    bit                         row_store [$];
    int                         row_test  [$];
    int                         itm [8];
    int                         cur_test;
    integer                     seed;
    bit                         table_ready;

    always #10 clk = ~clk;

    hdc_accel #(.DIM(DIM), .THREADS(THREADS), .ITEMS(ITEMS), .SEED(SEED)) i_hdc_accel (
        .clk(clk), .arst_n(arst_n), .run(run), .gen(gen), .update_item(update_item),
        .item_a(item_a), .get_v(get_v), .get_d(get_d), .store(store), .last(last),
        .core_result(core_result)
    );

    hdc_accel_checker #(.DIM(DIM), .THREADS(THREADS), .ITEMS(ITEMS), .SEED(SEED)) i_checker (
        .clk(clk), .arst_n(arst_n), .run(run), .gen(gen), .update_item(update_item),
        .item_a(item_a), .get_v(get_v), .get_d(get_d), .store(store), .last(last),
        .core_result(core_result), .test_end(test_end), .test_num(test_num),
        .exp_stores(exp_stores), .errors(errors), .tests_failed(tests_failed)
    );

    function automatic logic [15:0] load_item(input int a);
        logic [15:0] w;
        w = 16'(a);
        w[hdc_pkg::op_addr] = 1'b1;
        w[hdc_pkg::op_xor]  = 1'b1;
        return w;
    endfunction

    function automatic logic [15:0] write_back(input int a);
        logic [15:0] w;
        w = 16'(a);
        w[hdc_pkg::op_addr]  = 1'b1;
        w[hdc_pkg::op_store] = 1'b1;
        return w;
    endfunction

    function automatic logic [15:0] alu(input bit perm, xr, st, wr1, lst, sgn, input int sh);
        logic [15:0] w;
        w = 16'(sh);
        w[hdc_pkg::op_perm]  = perm;
        w[hdc_pkg::op_xor]   = xr;
        w[hdc_pkg::op_store] = st;
        w[hdc_pkg::op_wr_r1] = wr1;
        w[hdc_pkg::op_last]  = lst;
        w[hdc_pkg::op_sign]  = sgn;
        return w;
    endfunction

    task automatic add_row(input int fill, input logic [15:0] inst, input bit lvl, input bit st);
        row_fill.push_back(fill);
        row_inst.push_back(inst);
        row_run.push_back(lvl);
        row_store.push_back(st);
        row_test.push_back(cur_test);
    endtask

    task automatic strobe(input logic [15:0] inst, input bit st);
        add_row(-1, inst, 1'b1, st);
    endtask

    task automatic build_table();
        cur_test = 1;
        for (int k = 0; k < 8; k++) add_row(itm[k], '0, 1'b1, 1'b0);
        for (int k = 0; k < 4; k++) strobe(load_item(itm[k]), 1'b0);
        for (int k = 0; k < 4; k++) strobe(alu(0, 0, 1, 0, 0, 0, 0), 1'b1);
        // copy, reload, then bind with rotated sources
        cur_test = 2;
        for (int k = 0; k < 4; k++) strobe(load_item(itm[k+4]), 1'b0);
        for (int k = 0; k < 4; k++) strobe(alu(0, 0, 0, 1, 0, 0, 0), 1'b0);
        for (int k = 0; k < 4; k++) strobe(load_item(itm[k]), 1'b0);
        for (int k = 0; k < 4; k++) strobe(alu(k != 0, 1, 0, 0, 0, 0, SHIFTS[k]), 1'b0);
        for (int k = 0; k < 4; k++) strobe(alu(0, 0, 1, 0, 0, 0, 0), 1'b1);
        cur_test = 3;
        for (int k = 0; k < 4; k++) strobe(load_item(itm[(k+2)%8]), 1'b0);
        for (int k = 0; k < 4; k++) strobe(alu(1, 0, 0, 1, 0, 0, k + 1), 1'b0);
        for (int k = 0; k < 4; k++) strobe(alu(0, 1, 0, 0, 0, 0, 0), 1'b0);
        for (int k = 0; k < 4; k++) strobe(alu(0, 0, 1, 0, 0, 0, 0), 1'b1);
        // each thread reads back what its neighbour wrote
        cur_test = 4;
        for (int k = 0; k < 4; k++) strobe(load_item(itm[k+4]), 1'b0);
        for (int k = 0; k < 4; k++) strobe(write_back(508 + k), 1'b0);
        for (int k = 0; k < 4; k++) strobe(load_item(508 + (k + 1) % 4), 1'b0);
        for (int k = 0; k < 4; k++) strobe(alu(0, 0, 1, 0, 0, 0, 0), 1'b1);
        cur_test = 5;
        for (int k = 0; k < 4; k++) strobe((k < 3) ? load_item(itm[k]) : 16'h0, 1'b0);
        for (int k = 0; k < 4; k++) strobe(alu(0, 0, k < 3, 0, 0, 0, 0), k < 3);
        strobe(alu(0, 0, 0, 0, 0, 1, 0), 1'b0);
        for (int k = 0; k < 3; k++) strobe(16'h0, 1'b0);
        strobe(alu(0, 0, 1, 0, 0, 0, 0), 1'b1);
        // strobes while stopped must not execute
        cur_test = 6;
        for (int k = 0; k < 2; k++) add_row(-1, alu(0, 0, 1, 0, 0, 0, 0), 1'b0, 1'b0);
        for (int k = 0; k < 3; k++) strobe(16'h0, 1'b0);
        strobe(alu(0, 0, 0, 0, 1, 0, 0), 1'b0);
    endtask

    task automatic close_test(input int t);
        int n;
        n = 0;
        foreach (row_test[i]) begin
            if (row_test[i] == t && row_store[i]) n++;
        end
        @(posedge clk);
        gen         <= 1'b0;
        update_item <= 1'b0;
        get_v       <= 1'b0;
        get_d       <= '0;
        repeat (3) @(posedge clk);
        test_num   <= t;
        exp_stores <= n;
        test_end   <= 1'b1;
        @(posedge clk);
        test_end <= 1'b0;
        run      <= 1'b0;
        repeat (2) @(posedge clk);
        run <= 1'b1;
    endtask

    initial begin
        clk         = 1'b0;
        arst_n      = 1'b0;
        run         = 1'b0;
        gen         = 1'b0;
        update_item = 1'b0;
        item_a      = '0;
        get_v       = 1'b0;
        get_d       = '0;
        test_end    = 1'b0;
        test_num    = 0;
        exp_stores  = 0;
        seed = 32'h52a218af;
        for (int k = 0; k < 8; k++) itm[k] = $random(seed) & 255;
        build_table();
        table_ready = 1'b1;
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;
        repeat (2) @(posedge clk);
        run <= 1'b1;
        for (int r = 0; r < row_inst.size(); r++) begin
            if (r > 0 && row_test[r] != row_test[r-1]) close_test(row_test[r-1]);
            @(posedge clk);
            gen         <= (row_fill[r] >= 0);
            update_item <= (row_fill[r] >= 0);
            item_a      <= (row_fill[r] >= 0) ? row_fill[r][hdc_pkg::addr_w-1:0] : '0;
            get_v       <= (row_fill[r] < 0);
            get_d       <= (row_fill[r] < 0) ? row_inst[r] : '0;
            run         <= row_run[r];
        end
        close_test(row_test[row_test.size()-1]);
        @(posedge clk);
        $display("summary: %0d tests, %0d failed, %0d errors", TESTS, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // limit grows with the table, about ten cycles of overhead per test
    initial begin
        wait (table_ready);
        #((row_inst.size() + 10 * TESTS + 16 + 40) * 20);
        $display("timeout: the stimulus table did not complete in time");
        $display("test failed");
        $finish;
    end

endmodule

/* tb.f */
src/hdc_pkg.sv
src/hv_permute.sv
src/hv_rng.sv
src/hv_bundler.sv
src/hv_core.sv
src/hdc_accel.sv
dv/hdc_accel_checker.sv
dv/hdc_accel_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module hdc_accel_tb \
    -f tb.f -o hdc_accel_sim && ./obj_dir/hdc_accel_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "test passed" sim.log 2>/dev/null && echo "simulation ok" && exit 0 || {
    echo "simulation not ok"
    exit 1
}
